// File: compile.f
verilog/trigger_pkg.sv
verilog/trigger_cfg_if.sv
verilog/trigger_regs.sv
verilog/trigger_input.sv
verilog/trigger_fsm.sv
verilog/trigger_fifo.sv
verilog/trigger_controller.sv
tests/trigger_checker.sv
tests/tb_trigger_controller.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_trigger_controller -o sim_tb

out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -q "^Simulation passed$"

// File: tests/tb_trigger_controller.sv
module tb_trigger_controller;

    logic                       BUS_CLK;
    logic                       RST;
    trigger_pkg::bus_addr_t     bus_add;
    trigger_pkg::bus_data_t     bus_data_in;
    logic                       bus_rd;
    logic                       bus_wr;
    trigger_pkg::bus_data_t     bus_data_out;
    trigger_pkg::trig_vec_t     trigger;
    trigger_pkg::trig_vec_t     trigger_veto;
    logic                       ext_trigger_enable;
    logic                       trigger_acknowledge;
    logic                       trigger_accepted_flag;
    logic                       trigger_enabled;
    trigger_pkg::count_t        timestamp;
    logic                       fifo_read;
    logic                       fifo_empty;
    trigger_pkg::trigger_word_t fifo_data;

    integer                     seed = 94;
    int                         errors = 0;
    int                         checks = 0;
    int                         test_errors = 0;
    int                         cycles = 0;
    trigger_pkg::count_t        model_count;  // counter after the last accept
    trigger_pkg::count_t        ts_model;     // timestamp expected in the current cycle
    logic [1:0]                 model_fmt;
    trigger_pkg::trigger_word_t model_q[$];

    trigger_controller trigger_controller_inst (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    always @(posedge BUS_CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == 20000)  // longest test run is well below this
        begin
            $display("timeout: run did not finish within 20000 cycles");
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic trigger_pkg::trigger_word_t expected_word(input logic [1:0] fmt,
            input trigger_pkg::count_t cnt, input trigger_pkg::count_t ts);
        case (fmt)
            2'd1:    return {1'b1, ts[30:0]};
            2'd2:    return {1'b1, ts[14:0], cnt[15:0]};
            default: return {1'b1, cnt[30:0]};
        endcase
    endfunction

    // model of the data path, values seen before the edge
    always @(posedge BUS_CLK)
    begin
        if (!RST && trigger_accepted_flag)
        begin
            check("timestamp", timestamp, ts_model);
            model_count = model_count + 32'd1;
            if (model_q.size() < trigger_pkg::FIFO_DEPTH)
                model_q.push_back(expected_word(model_fmt, model_count, timestamp));
        end
        if (RST || (bus_wr && bus_add == trigger_pkg::ADDR_VERSION_RST))
            ts_model = '0;  // cleared by hard and soft reset
        else
            ts_model = ts_model + 32'd1;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge BUS_CLK);
        #1;
    endtask

    task automatic bus_write(input trigger_pkg::bus_addr_t a, input trigger_pkg::bus_data_t d);
        bus_add = a;
        bus_data_in = d;
        bus_wr = 1'b1;
        wait_cycles(1);
        bus_wr = 1'b0;
        if (a == trigger_pkg::ADDR_VERSION_RST)
        begin
            model_count = '0;
            model_fmt = 2'd0;
            model_q.delete();
        end
    endtask

    task automatic bus_read(input trigger_pkg::bus_addr_t a, output trigger_pkg::bus_data_t d);
        bus_add = a;
        bus_rd = 1'b1;
        wait_cycles(1);
        bus_rd = 1'b0;
        d = bus_data_out;
    endtask

    task automatic read_counter(output trigger_pkg::count_t c);
        trigger_pkg::bus_data_t b;
        for (int i = 0; i < 4; i++)
        begin
            bus_read(trigger_pkg::ADDR_COUNTER + 16'(i), b);
            c[8*i +: 8] = b;
        end
    endtask

    task automatic set_counter(input trigger_pkg::count_t c);
        for (int i = 0; i < 4; i++)
            bus_write(trigger_pkg::ADDR_COUNTER + 16'(i), c[8*i +: 8]);
        model_count = c;
    endtask

    task automatic pulse_input(input int idx, input trigger_pkg::trig_vec_t idle);
        trigger = idle ^ (trigger_pkg::trig_vec_t'(1) << idx);
        wait_cycles(10);
        trigger = idle;
        wait_cycles(10);
    endtask

    task automatic soft_trigger();
        bus_write(trigger_pkg::ADDR_SOFT_TRG, 8'h01);
        wait_cycles(6);  // back to IDLE
    endtask

    // pop every word and compare it with the model queue
    task automatic drain_fifo();
        while (!fifo_empty)
        begin
            if (model_q.size() == 0)
            begin
                $display("FIFO holds a word that no accepted trigger produced");
                errors++;
            end
            else
                check("fifo_data", fifo_data, model_q.pop_front());
            fifo_read = 1'b1;
            wait_cycles(1);
            fifo_read = 1'b0;
        end
        if (model_q.size() != 0)
        begin
            $display("FIFO ran empty while %0d expected words were missing", model_q.size());
            errors++;
        end
    endtask

    task automatic test_done(input int num, input string name);
        $display("test %0d %s: %s", num, name, (errors == test_errors) ? "ok" : "FAILED");
        test_errors = errors;
    endtask

    initial
    begin
        trigger_pkg::bus_data_t d;
        trigger_pkg::count_t    c;
        trigger_pkg::trig_vec_t sel;
        trigger_pkg::trig_vec_t inv;
        trigger_pkg::bus_addr_t reg_addr [8];
        int                     r;
        int                     idx;
        int                     n;

        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        trigger = '0;
        trigger_veto = '0;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read = 1'b0;
        model_count = '0;
        model_fmt = 2'd0;
        reg_addr = '{trigger_pkg::ADDR_SELECT, trigger_pkg::ADDR_VETO,
                     trigger_pkg::ADDR_INVERT, trigger_pkg::ADDR_THRESHOLD,
                     trigger_pkg::ADDR_COUNTER_MAX, trigger_pkg::ADDR_COUNTER_MAX + 16'd1,
                     trigger_pkg::ADDR_COUNTER_MAX + 16'd2, trigger_pkg::ADDR_COUNTER_MAX + 16'd3};
        wait_cycles(3);
        RST = 1'b0;

        bus_read(trigger_pkg::ADDR_VERSION_RST, d);
        check("version", 32'(d), 32'd10);
        for (int i = 0; i < 8; i++)
        begin
            bus_write(reg_addr[i], 8'(8'h5a + i));
            bus_read(reg_addr[i], d);
            check("readback", 32'(d), 32'(8'h5a + i));
        end
        bus_write(trigger_pkg::ADDR_VERSION_RST, 8'h00);
        for (int i = 0; i < 8; i++)
        begin
            bus_read(reg_addr[i], d);
            check("register after soft reset", 32'(d), 32'd0);
        end
        test_done(1, "registers");

        r = $random(seed);
        sel = r[7:0];
        r = $random(seed);
        inv = r[7:0];
        trigger = inv;  // inputs idle at the inverted level
        wait_cycles(4);
        bus_write(trigger_pkg::ADDR_INVERT, inv);
        bus_write(trigger_pkg::ADDR_SELECT, sel);
        bus_write(trigger_pkg::ADDR_CONF, 8'h08);
        n = 0;
        for (int i = 0; i < 6; i++)
        begin
            r = $random(seed);
            idx = int'(r[2:0]);
            if (sel[idx])
                n++;
            pulse_input(idx, inv);
        end
        soft_trigger();
        soft_trigger();
        read_counter(c);
        check("trigger counter", c, 32'(n + 2));
        drain_fifo();
        test_done(2, "selection and soft trigger");

        bus_write(trigger_pkg::ADDR_VERSION_RST, 8'h00);
        trigger = '0;
        bus_write(trigger_pkg::ADDR_SELECT, 8'h01);
        bus_write(trigger_pkg::ADDR_VETO, 8'h01);
        bus_write(trigger_pkg::ADDR_CONF, 8'h08);
        trigger_veto = 8'h01;
        wait_cycles(4);
        pulse_input(0, '0);
        pulse_input(0, '0);
        read_counter(c);
        check("counter under veto", c, 32'd0);
        trigger_veto = '0;
        bus_write(trigger_pkg::ADDR_COUNTER_MAX, 8'd3);
        for (int i = 0; i < 5; i++)
            pulse_input(0, '0);
        read_counter(c);
        check("counter at limit", c, 32'd3);
        check("trigger_enabled", 32'(trigger_enabled), 32'd0);
        set_counter(32'h00a1_b2c3);
        wait_cycles(1);
        read_counter(c);
        check("counter set", c, 32'h00a1_b2c3);
        drain_fifo();
        test_done(3, "veto and limit");

        for (int f = 0; f < 4; f++)
        begin
            bus_write(trigger_pkg::ADDR_VERSION_RST, 8'h00);
            bus_write(trigger_pkg::ADDR_CONF, 8'h08);
            bus_write(trigger_pkg::ADDR_FORMAT, 8'(f));
            model_fmt = 2'(f);
            set_counter(32'h7fff_fffe);  // crosses bit 31
            wait_cycles(2);
            soft_trigger();
            soft_trigger();
            drain_fifo();
        end
        test_done(4, "data formats");

        bus_write(trigger_pkg::ADDR_VERSION_RST, 8'h00);
        bus_write(trigger_pkg::ADDR_CONF, 8'h08);
        wait_cycles(2);
        for (int i = 0; i < 10; i++)
            soft_trigger();
        bus_read(trigger_pkg::ADDR_LOST, d);
        check("lost_count", 32'(d), 32'd2);
        drain_fifo();
        test_done(5, "overflow");

        bus_write(trigger_pkg::ADDR_VERSION_RST, 8'h00);
        bus_write(trigger_pkg::ADDR_SELECT, 8'h01);
        bus_write(trigger_pkg::ADDR_CONF, 8'h08);
        ext_trigger_enable = 1'b1;
        wait_cycles(4);
        for (int i = 0; i < 3; i++)
            pulse_input(0, '0);
        read_counter(c);
        check("counter before acknowledge", c, 32'd1);
        trigger_acknowledge = 1'b1;
        wait_cycles(1);
        trigger_acknowledge = 1'b0;
        wait_cycles(3);
        pulse_input(0, '0);
        read_counter(c);
        check("counter after acknowledge", c, 32'd2);
        ext_trigger_enable = 1'b0;
        drain_fifo();
        test_done(6, "external acknowledge");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: tests/trigger_checker.sv
module trigger_checker (
    input logic                    BUS_CLK,
    input logic                    RST,
    input trigger_pkg::fsm_state_t state,
    input logic                    trigger_enabled,
    input logic                    veto_level,
    input logic                    trigger_accepted_flag,
    input logic                    word_write
);

    // accept state never holds for two cycles
    accept_one_cycle: assert property (@(posedge BUS_CLK) disable iff (RST)
        state == trigger_pkg::ACCEPT |=> state != trigger_pkg::ACCEPT)
        else $error("ACCEPT state held longer than one cycle");

    // start decision is taken one cycle before the flag
    flag_needs_enable: assert property (@(posedge BUS_CLK) disable iff (RST)
        $rose(trigger_accepted_flag) |-> $past(trigger_enabled && !veto_level))
        else $error("trigger flag rose while disabled or vetoed");

    write_with_flag: assert property (@(posedge BUS_CLK) disable iff (RST)
        word_write == trigger_accepted_flag)
        else $error("word_write does not match trigger_accepted_flag");

endmodule

bind trigger_fsm trigger_checker trigger_checker_inst (
    .BUS_CLK               (BUS_CLK),
    .RST                   (RST),
    .state                 (state),
    .trigger_enabled       (trigger_enabled),
    .veto_level            (veto_level),
    .trigger_accepted_flag (trigger_accepted_flag),
    .word_write            (word_write)
);

// File: verilog/trigger_cfg_if.sv
interface trigger_cfg_if;

    logic                     trigger_enable;
    trigger_pkg::trig_vec_t   trigger_select;
    trigger_pkg::trig_vec_t   veto_select;
    trigger_pkg::trig_vec_t   trigger_invert;
    trigger_pkg::bus_data_t   threshold;          // run length in cycles
    trigger_pkg::data_fmt_t   data_format;
    trigger_pkg::count_t      counter_max;        // 0 = no limit
    logic                     soft_trigger;       // one cycle strobe
    logic                     counter_set;        // one cycle strobe
    trigger_pkg::count_t      counter_set_value;

    modport regs (
        output trigger_enable, trigger_select, veto_select, trigger_invert, threshold,
        output data_format, counter_max, soft_trigger, counter_set, counter_set_value
    );

    modport datapath (
        input trigger_enable, trigger_select, veto_select, trigger_invert, threshold,
        input data_format, counter_max, soft_trigger, counter_set, counter_set_value
    );

endinterface

// File: verilog/trigger_controller.sv
module trigger_controller (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  trigger_pkg::bus_addr_t     bus_add,
    input  trigger_pkg::bus_data_t     bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    output trigger_pkg::bus_data_t     bus_data_out,
    input  trigger_pkg::trig_vec_t     trigger,
    input  trigger_pkg::trig_vec_t     trigger_veto,
    input  logic                       ext_trigger_enable,
    input  logic                       trigger_acknowledge,
    output logic                       trigger_accepted_flag,
    output logic                       trigger_enabled,
    output trigger_pkg::count_t        timestamp,
    input  logic                       fifo_read,
    output logic                       fifo_empty,
    output trigger_pkg::trigger_word_t fifo_data
);

    logic                       soft_rst;
    logic                       rst_all;   // hard or soft reset
    logic                       trigger_level;
    logic                       veto_level;
    logic                       word_write;
    trigger_pkg::trigger_word_t word_data;
    trigger_pkg::count_t        trigger_count;
    trigger_pkg::bus_data_t     lost_count;

    assign rst_all = RST || soft_rst;

    trigger_cfg_if cfg_if ();

    trigger_regs trigger_regs_inst (
        .BUS_CLK       (BUS_CLK),
        .RST           (RST),
        .bus_add       (bus_add),
        .bus_data_in   (bus_data_in),
        .bus_rd        (bus_rd),
        .bus_wr        (bus_wr),
        .bus_data_out  (bus_data_out),
        .cfg           (cfg_if),
        .trigger_count (trigger_count),
        .lost_count    (lost_count),
        .soft_rst      (soft_rst)
    );

    trigger_input trigger_input_inst (
        .BUS_CLK       (BUS_CLK),
        .RST           (rst_all),
        .trigger       (trigger),
        .trigger_veto  (trigger_veto),
        .cfg           (cfg_if),
        .trigger_level (trigger_level),
        .veto_level    (veto_level)
    );

    trigger_fsm trigger_fsm_inst (
        .BUS_CLK               (BUS_CLK),
        .RST                   (rst_all),
        .cfg                   (cfg_if),
        .trigger_level         (trigger_level),
        .veto_level            (veto_level),
        .ext_trigger_enable    (ext_trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag),
        .trigger_enabled       (trigger_enabled),
        .timestamp             (timestamp),
        .trigger_count         (trigger_count),
        .word_write            (word_write),
        .word_data             (word_data)
    );

    trigger_fifo trigger_fifo_inst (
        .BUS_CLK    (BUS_CLK),
        .RST        (rst_all),
        .word_write (word_write),
        .word_data  (word_data),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .lost_count (lost_count)
    );

endmodule

// File: verilog/trigger_fifo.sv
module trigger_fifo (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic                       word_write,
    input  trigger_pkg::trigger_word_t word_data,
    input  logic                       fifo_read,
    output logic                       fifo_empty,
    output trigger_pkg::trigger_word_t fifo_data,
    output trigger_pkg::bus_data_t     lost_count
);

    trigger_pkg::trigger_word_t mem [trigger_pkg::FIFO_DEPTH];
    trigger_pkg::fifo_ptr_t     wr_ptr;
    trigger_pkg::fifo_ptr_t     rd_ptr;
    trigger_pkg::fifo_cnt_t     count;
    logic                       full;
    logic                       push;
    logic                       pop;

    assign full       = (count == trigger_pkg::FIFO_FULL);
    assign fifo_empty = (count == '0);
    assign push       = word_write && !full;   // dropped when full
    assign pop        = fifo_read && !fifo_empty;
    assign fifo_data  = mem[rd_ptr];           // head word, valid while not empty

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= word_data;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            lost_count <= '0;
        else if (word_write && full && lost_count != 8'hff)
            lost_count <= lost_count + 8'd1;
    end

endmodule

// File: verilog/trigger_fsm.sv
module trigger_fsm (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    trigger_cfg_if.datapath            cfg,
    input  logic                       trigger_level,
    input  logic                       veto_level,
    input  logic                       ext_trigger_enable,
    input  logic                       trigger_acknowledge,
    output logic                       trigger_accepted_flag,
    output logic                       trigger_enabled,
    output trigger_pkg::count_t        timestamp,
    output trigger_pkg::count_t        trigger_count,
    output logic                       word_write,
    output trigger_pkg::trigger_word_t word_data
);

    trigger_pkg::fsm_state_t state;
    logic                    level_d;
    logic                    limit_reached;
    logic                    start;
    trigger_pkg::count_t     count_next;

    assign limit_reached = (cfg.counter_max != '0) && (trigger_count >= cfg.counter_max);
    assign start = trigger_enabled && !veto_level
                   && ((trigger_level && !level_d) || cfg.soft_trigger);
    assign count_next = trigger_count + 32'd1;

    assign trigger_accepted_flag = (state == trigger_pkg::ACCEPT);
    assign word_write = (state == trigger_pkg::ACCEPT);  // one word per accept

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state           <= trigger_pkg::IDLE;
            level_d         <= 1'b0;
            trigger_enabled <= 1'b0;
            timestamp       <= '0;
        end
        else
        begin
            level_d         <= trigger_level;
            trigger_enabled <= cfg.trigger_enable && !limit_reached;
            timestamp       <= timestamp + 32'd1;  // free running
            case (state)
                trigger_pkg::IDLE:
                    if (start)
                        state <= trigger_pkg::ACCEPT;
                trigger_pkg::ACCEPT:
                    state <= trigger_pkg::WAIT_ACK;
                trigger_pkg::WAIT_ACK:
                    if (!ext_trigger_enable || trigger_acknowledge)
                        state <= trigger_pkg::WAIT_LOW;
                default:
                    if (!trigger_level)
                        state <= trigger_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            trigger_count <= '0;
        else if (cfg.counter_set)
            trigger_count <= cfg.counter_set_value;
        else if (state == trigger_pkg::ACCEPT)
            trigger_count <= count_next;
    end

    always_comb
    begin
        case (cfg.data_format)
            trigger_pkg::FMT_TIMESTAMP: word_data = {1'b1, timestamp[30:0]};
            trigger_pkg::FMT_COMBINED:  word_data = {1'b1, timestamp[14:0], count_next[15:0]};
            default:                    word_data = {1'b1, count_next[30:0]};
        endcase
    end

endmodule

// File: verilog/trigger_input.sv
module trigger_input (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  trigger_pkg::trig_vec_t trigger,
    input  trigger_pkg::trig_vec_t trigger_veto,
    trigger_cfg_if.datapath        cfg,
    output logic                   trigger_level,
    output logic                   veto_level
);

    trigger_pkg::trig_vec_t trig_meta;
    trigger_pkg::trig_vec_t trig_sync;
    trigger_pkg::trig_vec_t veto_meta;
    trigger_pkg::trig_vec_t veto_sync;
    logic                   trig_any;
    trigger_pkg::bus_data_t run_cnt;   // consecutive high cycles so far
    logic [8:0]             run_next;

    // invert first, then select
    assign trig_any = |((trig_sync ^ cfg.trigger_invert) & cfg.trigger_select);
    assign run_next = {1'b0, run_cnt} + 9'd1;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trig_meta <= '0;
            trig_sync <= '0;
            veto_meta <= '0;
            veto_sync <= '0;
        end
        else
        begin
            trig_meta <= trigger;
            trig_sync <= trig_meta;
            veto_meta <= trigger_veto;
            veto_sync <= veto_meta;
        end
    end

    // threshold 0 and 1 both pass on the first high cycle
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || !trig_any)
        begin
            run_cnt       <= '0;
            trigger_level <= 1'b0;
        end
        else
        begin
            if (run_cnt != 8'hff)
                run_cnt <= run_next[7:0];  // saturate
            trigger_level <= run_next >= {1'b0, cfg.threshold};
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            veto_level <= 1'b0;
        else
            veto_level <= |(veto_sync & cfg.veto_select);  // same latency as trigger_level
    end

endmodule

// File: verilog/trigger_pkg.sv
package trigger_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;
    typedef logic [7:0]  trig_vec_t;
    typedef logic [31:0] count_t;
    typedef logic [31:0] trigger_word_t;
    typedef logic [1:0]  data_fmt_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCEPT,
        WAIT_ACK,
        WAIT_LOW
    } fsm_state_t;

    localparam bus_data_t VERSION = 8'd10;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;
    localparam fifo_cnt_t FIFO_FULL = fifo_cnt_t'(FIFO_DEPTH);

    // register map
    localparam bus_addr_t ADDR_VERSION_RST = 16'd0;  // write = soft reset
    localparam bus_addr_t ADDR_CONF        = 16'd1;
    localparam bus_addr_t ADDR_FORMAT      = 16'd2;
    localparam bus_addr_t ADDR_COUNTER     = 16'd8;  // 8 to 11, little endian
    localparam bus_addr_t ADDR_LOST        = 16'd12;
    localparam bus_addr_t ADDR_SELECT      = 16'd13;
    localparam bus_addr_t ADDR_VETO        = 16'd17;
    localparam bus_addr_t ADDR_INVERT      = 16'd21;
    localparam bus_addr_t ADDR_COUNTER_MAX = 16'd25; // 25 to 28
    localparam bus_addr_t ADDR_THRESHOLD   = 16'd33;
    localparam bus_addr_t ADDR_SOFT_TRG    = 16'd34;

    localparam int CONF_ENABLE_BIT = 3;

    // data word formats, code 3 falls back to counter
    localparam data_fmt_t FMT_COUNTER   = 2'd0;
    localparam data_fmt_t FMT_TIMESTAMP = 2'd1;
    localparam data_fmt_t FMT_COMBINED  = 2'd2;

endpackage

// File: verilog/trigger_regs.sv
module trigger_regs (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  trigger_pkg::bus_addr_t bus_add,
    input  trigger_pkg::bus_data_t bus_data_in,
    input  logic                   bus_rd,
    input  logic                   bus_wr,
    output trigger_pkg::bus_data_t bus_data_out,
    trigger_cfg_if.regs            cfg,
    input  trigger_pkg::count_t    trigger_count,
    input  trigger_pkg::bus_data_t lost_count,
    output logic                   soft_rst
);

    logic                   rst_regs;
    trigger_pkg::bus_data_t conf_reg;
    trigger_pkg::bus_data_t format_reg;
    trigger_pkg::trig_vec_t select_reg;
    trigger_pkg::trig_vec_t veto_reg;
    trigger_pkg::trig_vec_t invert_reg;
    trigger_pkg::bus_data_t threshold_reg;
    trigger_pkg::count_t    counter_max_reg;
    logic [23:0]            count_set_low;  // bytes written to 8..10
    trigger_pkg::count_t    count_snap;     // latched on read of address 8

    assign soft_rst = bus_wr && (bus_add == trigger_pkg::ADDR_VERSION_RST);
    assign rst_regs = RST || soft_rst;

    assign cfg.trigger_enable = conf_reg[trigger_pkg::CONF_ENABLE_BIT];
    assign cfg.data_format    = format_reg[1:0];
    assign cfg.trigger_select = select_reg;
    assign cfg.veto_select    = veto_reg;
    assign cfg.trigger_invert = invert_reg;
    assign cfg.threshold      = threshold_reg;
    assign cfg.counter_max    = counter_max_reg;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_regs)
        begin
            conf_reg        <= '0;
            format_reg      <= '0;
            select_reg      <= '0;
            veto_reg        <= '0;
            invert_reg      <= '0;
            threshold_reg   <= '0;
            counter_max_reg <= '0;
            count_set_low   <= '0;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                trigger_pkg::ADDR_CONF:                 conf_reg <= bus_data_in;
                trigger_pkg::ADDR_FORMAT:               format_reg <= bus_data_in;
                trigger_pkg::ADDR_COUNTER:              count_set_low[7:0] <= bus_data_in;
                trigger_pkg::ADDR_COUNTER + 16'd1:      count_set_low[15:8] <= bus_data_in;
                trigger_pkg::ADDR_COUNTER + 16'd2:      count_set_low[23:16] <= bus_data_in;
                trigger_pkg::ADDR_SELECT:               select_reg <= bus_data_in;
                trigger_pkg::ADDR_VETO:                 veto_reg <= bus_data_in;
                trigger_pkg::ADDR_INVERT:               invert_reg <= bus_data_in;
                trigger_pkg::ADDR_COUNTER_MAX:          counter_max_reg[7:0] <= bus_data_in;
                trigger_pkg::ADDR_COUNTER_MAX + 16'd1:  counter_max_reg[15:8] <= bus_data_in;
                trigger_pkg::ADDR_COUNTER_MAX + 16'd2:  counter_max_reg[23:16] <= bus_data_in;
                trigger_pkg::ADDR_COUNTER_MAX + 16'd3:  counter_max_reg[31:24] <= bus_data_in;
                trigger_pkg::ADDR_THRESHOLD:            threshold_reg <= bus_data_in;
                default: ;
            endcase
        end
    end

    // strobes towards the datapath, one cycle after the write
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_regs)
        begin
            cfg.soft_trigger <= 1'b0;
            cfg.counter_set  <= 1'b0;
        end
        else
        begin
            cfg.soft_trigger <= bus_wr && (bus_add == trigger_pkg::ADDR_SOFT_TRG);
            cfg.counter_set  <= bus_wr && (bus_add == trigger_pkg::ADDR_COUNTER + 16'd3);
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        cfg.counter_set_value <= {bus_data_in, count_set_low};  // used with counter_set only
        if (bus_rd && bus_add == trigger_pkg::ADDR_COUNTER)
            count_snap <= trigger_count;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_regs)
            bus_data_out <= '0;
        else if (bus_rd)
        begin
            case (bus_add)
                trigger_pkg::ADDR_VERSION_RST:          bus_data_out <= trigger_pkg::VERSION;
                trigger_pkg::ADDR_CONF:                 bus_data_out <= conf_reg;
                trigger_pkg::ADDR_FORMAT:               bus_data_out <= format_reg;
                trigger_pkg::ADDR_COUNTER:              bus_data_out <= trigger_count[7:0];
                trigger_pkg::ADDR_COUNTER + 16'd1:      bus_data_out <= count_snap[15:8];
                trigger_pkg::ADDR_COUNTER + 16'd2:      bus_data_out <= count_snap[23:16];
                trigger_pkg::ADDR_COUNTER + 16'd3:      bus_data_out <= count_snap[31:24];
                trigger_pkg::ADDR_LOST:                 bus_data_out <= lost_count;
                trigger_pkg::ADDR_SELECT:               bus_data_out <= select_reg;
                trigger_pkg::ADDR_VETO:                 bus_data_out <= veto_reg;
                trigger_pkg::ADDR_INVERT:               bus_data_out <= invert_reg;
                trigger_pkg::ADDR_COUNTER_MAX:          bus_data_out <= counter_max_reg[7:0];
                trigger_pkg::ADDR_COUNTER_MAX + 16'd1:  bus_data_out <= counter_max_reg[15:8];
                trigger_pkg::ADDR_COUNTER_MAX + 16'd2:  bus_data_out <= counter_max_reg[23:16];
                trigger_pkg::ADDR_COUNTER_MAX + 16'd3:  bus_data_out <= counter_max_reg[31:24];
                trigger_pkg::ADDR_THRESHOLD:            bus_data_out <= threshold_reg;
                default:                                bus_data_out <= '0;
            endcase
        end
    end

endmodule
